// File: alert_accumulator.sv
////////////////////////////////////////
// Class accumulator
// Saturating trigger count, flags the
// trigger at or past the threshold
////////////////////////////////////////

module alert_accumulator (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              class_en_i,
  input  logic                              clr_i,
  input  logic                              class_trig_i,
  input  logic [alert_pkg::ACCU_CNT_DW-1:0] thresh_i,
  output logic [alert_pkg::ACCU_CNT_DW-1:0] accu_cnt_o,
  output logic                              accu_trig_o
);

  import alert_pkg::*;

  logic [ACCU_CNT_DW-1:0] accu_cnt_q;
  logic                   trig_in;

  // Only count while the class is on
  assign trig_in = class_en_i & class_trig_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accu_cnt_q <= '0;
    end else if (clr_i) begin
      accu_cnt_q <= '0;
    end else if (trig_in && !(&accu_cnt_q)) begin
      accu_cnt_q <= accu_cnt_q + 1'b1;
    end
  end

  // Compare against the count before this trigger
  assign accu_trig_o = trig_in & (accu_cnt_q >= thresh_i);
  assign accu_cnt_o  = accu_cnt_q;

endmodule

// File: alert_classifier.sv
////////////////////////////////////////
// Alert classifier
// Sticky cause bits and per-class
// trigger pulses from enabled alerts
////////////////////////////////////////

module alert_classifier (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic [alert_pkg::N_ALERTS-1:0]                         alert_i,
  input  logic [alert_pkg::N_ALERTS-1:0]                         alert_en_i,
  input  logic [alert_pkg::N_ALERTS-1:0][alert_pkg::CLASS_W-1:0] alert_class_i,
  input  logic [alert_pkg::N_ALERTS-1:0]                         cause_clr_i,
  output logic [alert_pkg::N_ALERTS-1:0]                         cause_o,
  output logic [alert_pkg::N_CLASSES-1:0]                        class_trig_o
);

  import alert_pkg::*;

  logic [N_ALERTS-1:0] alert_trig;
  logic [N_ALERTS-1:0] cause_q;

  // Disabled alerts are dropped here
  assign alert_trig = alert_i & alert_en_i;

  // A new alert wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cause_q <= '0;
    end else begin
      cause_q <= (cause_q & ~cause_clr_i) | alert_trig;
    end
  end

  assign cause_o = cause_q;

  ////////////////////////////////////////
  // Class mapping
  ////////////////////////////////////////

  always_comb begin
    class_trig_o = '0;
    for (int k = 0; k < N_ALERTS; k++) begin
      if (alert_trig[k]) begin
        class_trig_o[alert_class_i[k]] = 1'b1;
      end
    end
  end

endmodule

// File: alert_esc_timer.sv
////////////////////////////////////////
// Escalation timer
// Interrupt timeout, four timed phases
// and severity request decode
////////////////////////////////////////

module alert_esc_timer (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  alert_pkg::class_cfg_t            cfg_i,
  input  logic                             clr_i,
  input  logic                             intr_i,
  input  logic                             accu_trig_i,
  output alert_pkg::esc_state_e            esc_state_o,
  output logic [alert_pkg::N_ESC_SEV-1:0]  esc_req_o
);

  import alert_pkg::*;

  esc_state_e            state_q;
  esc_state_e            state_d;
  esc_state_e            next_phase;
  logic [ESC_CNT_DW-1:0] cnt_q;
  logic [ESC_CNT_DW-1:0] cnt_d;
  logic [ESC_CNT_DW-1:0] phase_len;
  logic [CLASS_W-1:0]    phase_idx;
  logic                  in_phase;

  // Zero phase length behaves as one cycle
  assign phase_len = (cfg_i.phase_cyc == '0) ? ESC_CNT_DW'(1) : cfg_i.phase_cyc;

  // Phase index and successor
  always_comb begin
    in_phase   = 1'b1;
    phase_idx  = '0;
    next_phase = ESC_TERMINAL;
    case (state_q)
      ESC_PHASE0: begin
        phase_idx  = CLASS_W'(0);
        next_phase = ESC_PHASE1;
      end
      ESC_PHASE1: begin
        phase_idx  = CLASS_W'(1);
        next_phase = ESC_PHASE2;
      end
      ESC_PHASE2: begin
        phase_idx  = CLASS_W'(2);
        next_phase = ESC_PHASE3;
      end
      ESC_PHASE3: phase_idx = CLASS_W'(3);
      default:    in_phase  = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  // cnt_q holds the cycles spent so far in the current timed state
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ESC_IDLE: begin
        cnt_d = '0;
        if (cfg_i.en && accu_trig_i) begin
          state_d = ESC_PHASE0;
          cnt_d   = ESC_CNT_DW'(1);
        end else if (cfg_i.en && intr_i && cfg_i.timeout_cyc != '0) begin
          state_d = ESC_TIMEOUT;
          cnt_d   = ESC_CNT_DW'(1);
        end
      end
      ESC_TIMEOUT: begin
        if (!intr_i) begin
          state_d = ESC_IDLE;
          cnt_d   = '0;
        end else if ((cfg_i.en && accu_trig_i) || cnt_q >= cfg_i.timeout_cyc) begin
          state_d = ESC_PHASE0;
          cnt_d   = ESC_CNT_DW'(1);
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      ESC_PHASE0, ESC_PHASE1, ESC_PHASE2, ESC_PHASE3: begin
        if (cnt_q >= phase_len) begin
          state_d = next_phase;
          cnt_d   = ESC_CNT_DW'(1);
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      ESC_TERMINAL: cnt_d = '0;
      default: begin
        state_d = ESC_IDLE;
        cnt_d   = '0;
      end
    endcase
    // Class clear overrides everything
    if (clr_i) begin
      state_d = ESC_IDLE;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ESC_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // Severity decode
  ////////////////////////////////////////

  always_comb begin
    esc_req_o = '0;
    if (in_phase && cfg_i.esc_en[phase_idx]) begin
      esc_req_o[cfg_i.esc_map[phase_idx]] = 1'b1;
    end
  end

  assign esc_state_o = state_q;

endmodule

// File: alert_handler.sv
////////////////////////////////////////
// Alert handler top
// Register block, classifier, per-class
// accumulators and escalation timers
////////////////////////////////////////

module alert_handler (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  alert_pkg::reg_req_t             reg_req_i,
  input  logic [alert_pkg::N_ALERTS-1:0]  alert_i,
  output alert_pkg::reg_rsp_t             reg_rsp_o,
  output logic [alert_pkg::N_CLASSES-1:0] intr_o,
  output logic [alert_pkg::N_ESC_SEV-1:0] esc_o
);

  import alert_pkg::*;

  logic [N_ALERTS-1:0]                   alert_en;
  logic [N_ALERTS-1:0][CLASS_W-1:0]      alert_class;
  class_cfg_t [N_CLASSES-1:0]            class_cfg;
  logic [N_CLASSES-1:0]                  class_clr;
  logic [N_ALERTS-1:0]                   cause_clr;
  logic [N_ALERTS-1:0]                   cause;
  logic [N_CLASSES-1:0]                  class_trig;
  class_status_t [N_CLASSES-1:0]         class_status;
  logic [N_CLASSES-1:0][N_ESC_SEV-1:0]   class_esc_req;

  alert_reg_block u_reg_block (
    .clk_i,
    .reset_i,
    .reg_req_i,
    .class_trig_i  ( class_trig   ),
    .cause_i       ( cause        ),
    .status_i      ( class_status ),
    .reg_rsp_o,
    .alert_en_o    ( alert_en     ),
    .alert_class_o ( alert_class  ),
    .class_cfg_o   ( class_cfg    ),
    .class_clr_o   ( class_clr    ),
    .cause_clr_o   ( cause_clr    ),
    .intr_o
  );

  alert_classifier u_classifier (
    .clk_i,
    .reset_i,
    .alert_i,
    .alert_en_i    ( alert_en    ),
    .alert_class_i ( alert_class ),
    .cause_clr_i   ( cause_clr   ),
    .cause_o       ( cause       ),
    .class_trig_o  ( class_trig  )
  );

  ////////////////////////////////////////
  // Per-class escalation
  ////////////////////////////////////////

  for (genvar k = 0; k < N_CLASSES; k++) begin : gen_classes
    logic accu_trig;

    alert_accumulator u_accu (
      .clk_i,
      .reset_i,
      .class_en_i   ( class_cfg[k].en              ),
      .clr_i        ( class_clr[k]                 ),
      .class_trig_i ( class_trig[k]                ),
      .thresh_i     ( class_cfg[k].accu_thresh     ),
      .accu_cnt_o   ( class_status[k].accu_cnt     ),
      .accu_trig_o  ( accu_trig                    )
    );

    // The gated interrupt arms the timeout
    alert_esc_timer u_esc_timer (
      .clk_i,
      .reset_i,
      .cfg_i        ( class_cfg[k]                 ),
      .clr_i        ( class_clr[k]                 ),
      .intr_i       ( intr_o[k]                    ),
      .accu_trig_i  ( accu_trig                    ),
      .esc_state_o  ( class_status[k].esc_state    ),
      .esc_req_o    ( class_esc_req[k]             )
    );
  end

  // Any class may request any severity
  always_comb begin
    esc_o = '0;
    for (int k = 0; k < N_CLASSES; k++) begin
      esc_o |= class_esc_req[k];
    end
  end

endmodule

// File: alert_pkg.sv
////////////////////////////////////////
// Alert handler package
// Sizes, register map, configuration and
// status structs, escalation states
////////////////////////////////////////

package alert_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int N_ALERTS    = 8;
  localparam int N_CLASSES   = 4;
  localparam int N_ESC_SEV   = 4;
  localparam int N_PHASES    = 4;
  // Width of a class index and of a severity index
  localparam int CLASS_W     = 2;
  localparam int ACCU_CNT_DW = 16;
  localparam int ESC_CNT_DW  = 16;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [7:0] ADDR_ALERT_EN    = 8'h00;
  localparam logic [7:0] ADDR_ALERT_CLASS = 8'h04;
  localparam logic [7:0] ADDR_ALERT_CAUSE = 8'h08;
  localparam logic [7:0] ADDR_INTR_STATE  = 8'h0c;
  localparam logic [7:0] ADDR_INTR_ENABLE = 8'h10;

  // Class k lives at ADDR_CLASS_BASE + k * CLASS_STRIDE
  localparam logic [7:0] ADDR_CLASS_BASE  = 8'h20;
  localparam logic [7:0] CLASS_STRIDE     = 8'h20;

  localparam logic [7:0] OFS_CTRL      = 8'h00;
  localparam logic [7:0] OFS_CLR       = 8'h04;
  localparam logic [7:0] OFS_THRESH    = 8'h08;
  localparam logic [7:0] OFS_TIMEOUT   = 8'h0c;
  localparam logic [7:0] OFS_PHASE     = 8'h10;
  localparam logic [7:0] OFS_ACCU_CNT  = 8'h14;
  localparam logic [7:0] OFS_ESC_STATE = 8'h18;

  // Bit positions of the CTRL fields
  localparam int CTRL_EN_BIT     = 0;
  localparam int CTRL_ESC_EN_LSB = 1;
  localparam int CTRL_MAP_LSB    = 5;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef struct packed {
    logic        we;
    logic        re;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef enum logic [2:0] {
    ESC_IDLE     = 3'd0,
    ESC_TIMEOUT  = 3'd1,
    ESC_PHASE0   = 3'd2,
    ESC_PHASE1   = 3'd3,
    ESC_PHASE2   = 3'd4,
    ESC_PHASE3   = 3'd5,
    ESC_TERMINAL = 3'd6
  } esc_state_e;

  typedef struct packed {
    logic                              en;
    logic [N_PHASES-1:0]               esc_en;
    logic [N_PHASES-1:0][CLASS_W-1:0]  esc_map;
    logic [ACCU_CNT_DW-1:0]            accu_thresh;
    logic [ESC_CNT_DW-1:0]             timeout_cyc;
    logic [ESC_CNT_DW-1:0]             phase_cyc;
  } class_cfg_t;

  typedef struct packed {
    logic [ACCU_CNT_DW-1:0] accu_cnt;
    esc_state_e             esc_state;
  } class_status_t;

endpackage

// File: alert_reg_block.sv
////////////////////////////////////////
// Alert handler register block
// Global and per-class configuration,
// interrupt state and registered readback
////////////////////////////////////////

module alert_reg_block (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  alert_pkg::reg_req_t                                reg_req_i,
  input  logic [alert_pkg::N_CLASSES-1:0]                    class_trig_i,
  input  logic [alert_pkg::N_ALERTS-1:0]                     cause_i,
  input  alert_pkg::class_status_t [alert_pkg::N_CLASSES-1:0] status_i,
  output alert_pkg::reg_rsp_t                                reg_rsp_o,
  output logic [alert_pkg::N_ALERTS-1:0]                     alert_en_o,
  output logic [alert_pkg::N_ALERTS-1:0][alert_pkg::CLASS_W-1:0] alert_class_o,
  output alert_pkg::class_cfg_t [alert_pkg::N_CLASSES-1:0]   class_cfg_o,
  output logic [alert_pkg::N_CLASSES-1:0]                    class_clr_o,
  output logic [alert_pkg::N_ALERTS-1:0]                     cause_clr_o,
  output logic [alert_pkg::N_CLASSES-1:0]                    intr_o
);

  import alert_pkg::*;

  logic [N_ALERTS-1:0]               alert_en_q;
  logic [N_ALERTS-1:0][CLASS_W-1:0]  alert_class_q;
  logic [N_CLASSES-1:0]              intr_state_q;
  logic [N_CLASSES-1:0]              intr_enable_q;
  class_cfg_t [N_CLASSES-1:0]        class_cfg_q;

  logic [7:0]           class_rel;
  logic [7:0]           class_ofs;
  logic [CLASS_W-1:0]   class_idx;
  logic                 class_hit;
  logic [N_CLASSES-1:0] intr_clr;
  class_cfg_t           sel_cfg;
  class_status_t        sel_status;
  logic [31:0]          rdata;
  logic                 rvalid_q;
  logic [31:0]          rdata_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign class_rel = reg_req_i.addr - ADDR_CLASS_BASE;
  assign class_ofs = class_rel % CLASS_STRIDE;
  assign class_idx = CLASS_W'(class_rel / CLASS_STRIDE);
  assign class_hit = (reg_req_i.addr >= ADDR_CLASS_BASE) &&
                     (int'(class_rel) < N_CLASSES * int'(CLASS_STRIDE));

  assign sel_cfg    = class_cfg_q[class_idx];
  assign sel_status = status_i[class_idx];

  // Configuration writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alert_en_q    <= '0;
      alert_class_q <= '0;
      intr_enable_q <= '0;
      class_cfg_q   <= '0;
    end else if (reg_req_i.we) begin
      case (reg_req_i.addr)
        ADDR_ALERT_EN:    alert_en_q    <= reg_req_i.wdata[N_ALERTS-1:0];
        ADDR_ALERT_CLASS: alert_class_q <= reg_req_i.wdata[N_ALERTS*CLASS_W-1:0];
        ADDR_INTR_ENABLE: intr_enable_q <= reg_req_i.wdata[N_CLASSES-1:0];
        default: ;
      endcase
      if (class_hit) begin
        case (class_ofs)
          OFS_CTRL: begin
            class_cfg_q[class_idx].en      <= reg_req_i.wdata[CTRL_EN_BIT];
            class_cfg_q[class_idx].esc_en  <= reg_req_i.wdata[CTRL_ESC_EN_LSB +: N_PHASES];
            class_cfg_q[class_idx].esc_map <=
                reg_req_i.wdata[CTRL_MAP_LSB +: N_PHASES*CLASS_W];
          end
          OFS_THRESH:  class_cfg_q[class_idx].accu_thresh <= reg_req_i.wdata[ACCU_CNT_DW-1:0];
          OFS_TIMEOUT: class_cfg_q[class_idx].timeout_cyc <= reg_req_i.wdata[ESC_CNT_DW-1:0];
          OFS_PHASE:   class_cfg_q[class_idx].phase_cyc   <= reg_req_i.wdata[ESC_CNT_DW-1:0];
          default: ;
        endcase
      end
    end
  end

  // Write-one-to-clear masks and class clear pulses
  assign cause_clr_o = (reg_req_i.we && reg_req_i.addr == ADDR_ALERT_CAUSE) ?
                       reg_req_i.wdata[N_ALERTS-1:0] : '0;
  assign intr_clr    = (reg_req_i.we && reg_req_i.addr == ADDR_INTR_STATE) ?
                       reg_req_i.wdata[N_CLASSES-1:0] : '0;

  always_comb begin
    class_clr_o = '0;
    if (reg_req_i.we && class_hit && class_ofs == OFS_CLR) begin
      class_clr_o[class_idx] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////

  // New triggers win over a software clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | class_trig_i;
    end
  end

  assign intr_o = intr_state_q & intr_enable_q;

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (reg_req_i.addr)
      ADDR_ALERT_EN:    rdata[N_ALERTS-1:0]         = alert_en_q;
      ADDR_ALERT_CLASS: rdata[N_ALERTS*CLASS_W-1:0] = alert_class_q;
      ADDR_ALERT_CAUSE: rdata[N_ALERTS-1:0]         = cause_i;
      ADDR_INTR_STATE:  rdata[N_CLASSES-1:0]        = intr_state_q;
      ADDR_INTR_ENABLE: rdata[N_CLASSES-1:0]        = intr_enable_q;
      default: begin
        if (class_hit) begin
          case (class_ofs)
            OFS_CTRL: begin
              rdata[CTRL_EN_BIT]                        = sel_cfg.en;
              rdata[CTRL_ESC_EN_LSB +: N_PHASES]        = sel_cfg.esc_en;
              rdata[CTRL_MAP_LSB +: N_PHASES*CLASS_W]   = sel_cfg.esc_map;
            end
            OFS_THRESH:    rdata[ACCU_CNT_DW-1:0] = sel_cfg.accu_thresh;
            OFS_TIMEOUT:   rdata[ESC_CNT_DW-1:0]  = sel_cfg.timeout_cyc;
            OFS_PHASE:     rdata[ESC_CNT_DW-1:0]  = sel_cfg.phase_cyc;
            OFS_ACCU_CNT:  rdata[ACCU_CNT_DW-1:0] = sel_status.accu_cnt;
            OFS_ESC_STATE: rdata[$bits(esc_state_e)-1:0] = sel_status.esc_state;
            default: ;
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_req_i.re;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (reg_req_i.re) begin
      rdata_q <= rdata;
    end
  end

  assign reg_rsp_o.rvalid = rvalid_q;
  assign reg_rsp_o.rdata  = rdata_q;

  assign alert_en_o    = alert_en_q;
  assign alert_class_o = alert_class_q;
  assign class_cfg_o   = class_cfg_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the alert handler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_alert_handler \
  -o sim_alert_handler > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_alert_handler > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q "^PASS: all tests$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb_alert_handler.sv
////////////////////////////////////////
// Alert handler testbench
// Directed tests over the register port,
// alerts, interrupts and escalation
////////////////////////////////////////

module tb_alert_handler;

  import alert_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int ACC_THRESH  = 2;
  localparam int ACC_PHASE   = 3;
  localparam int TMO_SHORT   = 5;
  localparam int TMO_LONG    = 40;
  localparam int TMO_PHASE   = 2;
  localparam int CLR_PHASE   = 20;
  // Rough cost of one register access, and of the register traffic in one test
  localparam int REG_OP_CYC  = 4;
  localparam int TEST_CYC    = 90 * REG_OP_CYC;
  localparam int WATCHDOG_CYC = 2 * (4 + 5 * TEST_CYC + N_PHASES * ACC_PHASE + TMO_SHORT +
                                     N_PHASES * TMO_PHASE + TMO_LONG + 2 * CLR_PHASE);

  logic                 clk;
  logic                 reset;
  reg_req_t             reg_req;
  reg_rsp_t             reg_rsp;
  logic [N_ALERTS-1:0]  alert;
  logic [N_CLASSES-1:0] intr;
  logic [N_ESC_SEV-1:0] esc;
  integer               seed;

  alert_handler u_alert_handler (
    .clk_i     ( clk     ),
    .reset_i   ( reset   ),
    .reg_req_i ( reg_req ),
    .alert_i   ( alert   ),
    .reg_rsp_o ( reg_rsp ),
    .intr_o    ( intr    ),
    .esc_o     ( esc     )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input esc_state_e exp, input esc_state_e act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %s (%0d), actual %s (%0d)",
                               name, exp.name(), exp, act.name(), act));
    end
  endtask

  task automatic check_bits(input string name, input logic [N_ESC_SEV-1:0] exp,
                            input logic [N_ESC_SEV-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // Register port and alerts
  ////////////////////////////////////////

  function automatic logic [7:0] class_addr(input int k, input logic [7:0] ofs);
    return ADDR_CLASS_BASE + 8'(k) * CLASS_STRIDE + ofs;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic en, input logic [N_PHASES-1:0] esc_en,
                                            input logic [N_PHASES-1:0][CLASS_W-1:0] map);
    logic [31:0] word;
    word = '0;
    word[CTRL_EN_BIT] = en;
    word[CTRL_ESC_EN_LSB +: N_PHASES] = esc_en;
    word[CTRL_MAP_LSB +: N_PHASES*CLASS_W] = map;
    return word;
  endfunction

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_req.we    <= 1'b1;
    reg_req.addr  <= addr;
    reg_req.wdata <= data;
    @(posedge clk);
    reg_req.we    <= 1'b0;
  endtask

  // Returns at the negedge where rvalid is seen
  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    reg_req.re   <= 1'b1;
    reg_req.addr <= addr;
    @(posedge clk);
    reg_req.re <= 1'b0;
    @(negedge clk);
    while (!reg_rsp.rvalid) begin
      waited++;
      if (waited > 4) begin
        report_failure($sformatf("read of address %02h never returned rvalid", addr));
      end
      @(negedge clk);
    end
    if (waited != 0) begin
      report_failure($sformatf("read of address %02h answered %0d cycles late", addr, waited));
    end
    data = reg_rsp.rdata;
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    reg_read(addr, data);
    check_data(name, exp, data);
  endtask

  task automatic expect_state(input string name, input int k, input esc_state_e exp);
    logic [31:0] data;
    reg_read(class_addr(k, OFS_ESC_STATE), data);
    check_state(name, exp, esc_state_e'(data[2:0]));
  endtask

  // Returns at the edge that samples the pulse
  task automatic pulse_alert(input int idx);
    @(posedge clk);
    alert <= N_ALERTS'(1) << idx;
    @(posedge clk);
    alert <= '0;
  endtask

  task automatic restore_defaults();
    reg_write(ADDR_ALERT_EN, '0);
    reg_write(ADDR_ALERT_CLASS, '0);
    reg_write(ADDR_INTR_ENABLE, '0);
    for (int k = 0; k < N_CLASSES; k++) begin
      reg_write(class_addr(k, OFS_CTRL), '0);
      reg_write(class_addr(k, OFS_THRESH), '0);
      reg_write(class_addr(k, OFS_TIMEOUT), '0);
      reg_write(class_addr(k, OFS_PHASE), '0);
      reg_write(class_addr(k, OFS_CLR), '0);
    end
    reg_write(ADDR_ALERT_CAUSE, '1);
    reg_write(ADDR_INTR_STATE, '1);
    @(negedge clk);
    check_bits("restore: intr_o", '0, intr);
    check_bits("restore: esc_o", '0, esc);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_readback();
    logic [31:0] wdata;
    check_bits("reset: intr_o", '0, intr);
    check_bits("reset: esc_o", '0, esc);
    if (reg_rsp.rvalid !== 1'b0) begin
      report_failure("rvalid is not low after reset");
    end
    read_expect("reset: alert_en", ADDR_ALERT_EN, '0);
    read_expect("reset: alert_class", ADDR_ALERT_CLASS, '0);
    read_expect("reset: cause", ADDR_ALERT_CAUSE, '0);
    read_expect("reset: intr_state", ADDR_INTR_STATE, '0);
    read_expect("reset: intr_enable", ADDR_INTR_ENABLE, '0);
    for (int k = 0; k < N_CLASSES; k++) begin
      for (int o = 0; o <= int'(OFS_ESC_STATE); o += 4) begin
        read_expect($sformatf("reset: class %0d offset %02h", k, o), class_addr(k, 8'(o)), '0);
      end
    end
    // Unused upper bits read back as zero
    reg_write(ADDR_ALERT_EN, 32'hffff_ffa5);
    read_expect("readback: alert_en", ADDR_ALERT_EN, 32'h0000_00a5);
    reg_write(ADDR_ALERT_CLASS, 32'hdead_1e4b);
    read_expect("readback: alert_class", ADDR_ALERT_CLASS, 32'h0000_1e4b);
    reg_write(ADDR_INTR_ENABLE, 32'hffff_fff5);
    read_expect("readback: intr_enable", ADDR_INTR_ENABLE, 32'h0000_0005);
    for (int k = 0; k < N_CLASSES; k++) begin
      // Enable, four escalation enables and four 2-bit map fields
      wdata = 32'hffff_eaa5 + 32'(k);
      reg_write(class_addr(k, OFS_CTRL), wdata);
      read_expect($sformatf("readback: class %0d ctrl", k), class_addr(k, OFS_CTRL),
                  wdata & 32'h0000_1fff);
      reg_write(class_addr(k, OFS_THRESH), 32'h5a5a_1111 + 32'(k));
      read_expect($sformatf("readback: class %0d thresh", k), class_addr(k, OFS_THRESH),
                  32'h0000_1111 + 32'(k));
      reg_write(class_addr(k, OFS_TIMEOUT), 32'hffff_0100 + 32'(k));
      read_expect($sformatf("readback: class %0d timeout", k), class_addr(k, OFS_TIMEOUT),
                  32'h0000_0100 + 32'(k));
      reg_write(class_addr(k, OFS_PHASE), 32'h0003_0020 + 32'(k));
      read_expect($sformatf("readback: class %0d phase", k), class_addr(k, OFS_PHASE),
                  32'h0000_0020 + 32'(k));
    end
    restore_defaults();
  endtask

  task automatic test_cause_interrupt();
    logic [15:0] class_map;
    int          idx;
    int          cls;
    class_map = 16'h1be4;
    // Alert 7 stays disabled
    idx = int'($unsigned($random(seed)) % 7);
    cls = int'((class_map >> (2 * idx)) & 16'h3);
    reg_write(ADDR_ALERT_CLASS, {16'h0000, class_map});
    reg_write(ADDR_ALERT_EN, 32'h0000_007f);
    pulse_alert(idx);
    @(negedge clk);
    check_bits("cause: intr_o masked", '0, intr);
    read_expect("cause: cause bit", ADDR_ALERT_CAUSE, 32'(1) << idx);
    read_expect("cause: intr_state", ADDR_INTR_STATE, 32'(1) << cls);
    reg_write(ADDR_INTR_ENABLE, 32'h0000_000f);
    @(negedge clk);
    check_bits("cause: intr_o enabled", N_CLASSES'(1) << cls, intr);
    pulse_alert(7);
    read_expect("cause: disabled alert cause", ADDR_ALERT_CAUSE, 32'(1) << idx);
    read_expect("cause: disabled alert intr_state", ADDR_INTR_STATE, 32'(1) << cls);
    reg_write(ADDR_ALERT_CAUSE, 32'(1) << idx);
    read_expect("cause: cause cleared", ADDR_ALERT_CAUSE, '0);
    reg_write(ADDR_INTR_STATE, 32'(1) << cls);
    @(negedge clk);
    check_bits("cause: intr_o cleared", '0, intr);
    read_expect("cause: intr_state cleared", ADDR_INTR_STATE, '0);
    restore_defaults();
  endtask

  task automatic test_accum_escalation();
    logic [N_PHASES-1:0][CLASS_W-1:0] map;
    map = {2'd1, 2'd3, 2'd0, 2'd2};
    // Alert 0 maps to class 0 with the class register at zero
    reg_write(ADDR_ALERT_EN, 32'h0000_0001);
    reg_write(class_addr(0, OFS_THRESH), ACC_THRESH);
    reg_write(class_addr(0, OFS_PHASE), ACC_PHASE);
    reg_write(class_addr(0, OFS_CTRL), ctrl_word(1'b1, 4'hf, map));
    for (int i = 1; i <= ACC_THRESH; i++) begin
      pulse_alert(0);
      @(negedge clk);
      check_bits("accum: esc_o while counting", '0, esc);
      read_expect("accum: count", class_addr(0, OFS_ACCU_CNT), 32'(i));
      expect_state("accum: state while counting", 0, ESC_IDLE);
    end
    pulse_alert(0);
    for (int p = 0; p < N_PHASES; p++) begin
      for (int c = 0; c < ACC_PHASE; c++) begin
        @(negedge clk);
        check_bits($sformatf("accum: esc_o phase %0d cycle %0d", p, c),
                   N_ESC_SEV'(1) << map[p], esc);
      end
    end
    @(negedge clk);
    check_bits("accum: esc_o in terminal", '0, esc);
    expect_state("accum: terminal state", 0, ESC_TERMINAL);
    read_expect("accum: final count", class_addr(0, OFS_ACCU_CNT), 32'(ACC_THRESH + 1));
    expect_state("accum: terminal holds", 0, ESC_TERMINAL);
    restore_defaults();
  endtask

  task automatic test_timeout_escalation();
    // Alert 1 goes to class 1
    reg_write(ADDR_ALERT_CLASS, 32'h0000_0004);
    reg_write(ADDR_ALERT_EN, 32'h0000_0002);
    reg_write(ADDR_INTR_ENABLE, 32'h0000_0002);
    reg_write(class_addr(1, OFS_THRESH), 32'h0000_ffff);
    reg_write(class_addr(1, OFS_TIMEOUT), TMO_SHORT);
    reg_write(class_addr(1, OFS_PHASE), TMO_PHASE);
    reg_write(class_addr(1, OFS_CTRL), ctrl_word(1'b1, 4'hf, {4{2'd3}}));
    pulse_alert(1);
    @(negedge clk);
    check_bits("timeout: intr_o", 4'b0010, intr);
    check_bits("timeout: esc_o idle", '0, esc);
    for (int i = 1; i <= TMO_SHORT; i++) begin
      @(negedge clk);
      check_bits($sformatf("timeout: esc_o timeout cycle %0d", i), '0, esc);
    end
    @(negedge clk);
    check_bits("timeout: esc_o in phase 0", 4'b1000, esc);
    reg_write(ADDR_INTR_STATE, 32'h0000_0002);
    reg_write(class_addr(1, OFS_CLR), '0);
    expect_state("timeout: idle after clear", 1, ESC_IDLE);
    // Interrupt dropped before expiry
    reg_write(class_addr(1, OFS_TIMEOUT), TMO_LONG);
    pulse_alert(1);
    expect_state("timeout: counting", 1, ESC_TIMEOUT);
    reg_write(ADDR_INTR_STATE, 32'h0000_0002);
    expect_state("timeout: idle after intr clear", 1, ESC_IDLE);
    repeat (TMO_LONG + 5) begin
      @(negedge clk);
      check_bits("timeout: esc_o after intr clear", '0, esc);
    end
    expect_state("timeout: still idle", 1, ESC_IDLE);
    restore_defaults();
  endtask

  task automatic test_class_clear();
    int waited;
    waited = 0;
    // Alert 2 to class 2, alert 3 to class 3
    reg_write(ADDR_ALERT_CLASS, 32'h0000_00e0);
    reg_write(ADDR_ALERT_EN, 32'h0000_000c);
    reg_write(class_addr(2, OFS_PHASE), CLR_PHASE);
    reg_write(class_addr(3, OFS_PHASE), CLR_PHASE);
    reg_write(class_addr(2, OFS_CTRL), ctrl_word(1'b1, 4'hf, {2'd0, 2'd0, 2'd0, 2'd1}));
    reg_write(class_addr(3, OFS_CTRL), ctrl_word(1'b1, 4'hf, {2'd0, 2'd0, 2'd3, 2'd2}));
    pulse_alert(2);
    pulse_alert(3);
    @(negedge clk);
    check_bits("clear: esc_o both classes", 4'b0110, esc);
    read_expect("clear: class 2 count", class_addr(2, OFS_ACCU_CNT), 32'd1);
    reg_write(class_addr(2, OFS_CLR), '0);
    @(negedge clk);
    check_bits("clear: esc_o after clear", 4'b0100, esc);
    while (esc === 4'b0100) begin
      waited++;
      if (waited > CLR_PHASE + 2) begin
        report_failure("class 3 never left phase 0 after the class 2 clear");
      end
      @(negedge clk);
    end
    check_bits("clear: class 3 phase 1", 4'b1000, esc);
    expect_state("clear: class 3 state", 3, ESC_PHASE1);
    expect_state("clear: class 2 state", 2, ESC_IDLE);
    read_expect("clear: class 2 count", class_addr(2, OFS_ACCU_CNT), '0);
    read_expect("clear: class 3 count", class_addr(3, OFS_ACCU_CNT), 32'd1);
    restore_defaults();
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  initial begin
    seed    = 32'hca0ddf9c;
    reset   = 1'b1;
    reg_req = '0;
    alert   = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset_readback();
    test_cause_interrupt();
    test_accum_escalation();
    test_timeout_escalation();
    test_class_clear();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    report_failure($sformatf("watchdog expired after %0d cycles, the run did not finish",
                             WATCHDOG_CYC));
  end

endmodule

// File: verilog.f
alert_pkg.sv
alert_reg_block.sv
alert_classifier.sv
alert_accumulator.sv
alert_esc_timer.sv
alert_handler.sv
tb_alert_handler.sv
